// ==== hdl/cam_buf_pkg.sv ====
// Shared widths, defaults and word layouts for the camera capture design
// Imported by the RTL blocks and by the testbench reference model
`default_nettype none

package cam_buf_pkg;

	// ----------------------------------------
	// Bus and data widths
	// ----------------------------------------
	localparam int DATA_W         = 32;  // Host and buffer word
	localparam int CAM_BYTE_W     = 8;   // One camera byte
	localparam int BYTES_PER_WORD = 4;   // Bytes packed per word
	localparam int ADR_W          = 11;  // Host address bus

	// Words per ping-pong bank
	localparam int BANK_DEPTH_DEF = 512;

	// ----------------------------------------
	// Status word bit positions
	// ----------------------------------------
	localparam int STAT_BANK_BIT  = 0;   // Bank being filled
	localparam int STAT_VSYNC_BIT = 8;   // Live vsync level
	localparam int STAT_CAPEN_BIT = 16;  // Capture enable echo

	// ----------------------------------------
	// Control word
	// ----------------------------------------
	// Host writes the raw view and logic reads the fields
	typedef struct packed {
		logic [DATA_W-2:0] rsvd;        // Reserved bits
		logic              capture_en;  // Bit 0 enables byte capture
	} ctrl_fields_t;

	typedef union packed {
		logic [DATA_W-1:0] raw;
		ctrl_fields_t      f;
	} ctrl_word_u;

endpackage

`default_nettype wire

// ==== hdl/cam_wr_if.sv ====
// Packed-word write stream from the byte packer
// The buffer takes the write, the host slave only watches the bank bit
`default_nettype none

interface cam_wr_if #(
	parameter int BANK_DEPTH = cam_buf_pkg::BANK_DEPTH_DEF
);
	import cam_buf_pkg::*;

	localparam int PTR_W = $clog2(2 * BANK_DEPTH);  // Index over both banks

	logic              wr_en;    // One-cycle write pulse
	logic [PTR_W-1:0]  wr_addr;  // Word index
	logic [DATA_W-1:0] wr_data;  // Completed word
	logic              wr_bank;  // Bank of the next write

	modport producer (output wr_en, output wr_addr, output wr_data, output wr_bank);
	modport buffer   (input wr_en, input wr_addr, input wr_data);
	modport monitor  (input wr_bank);

endinterface

`default_nettype wire

// ==== hdl/cam_byte_packer.sv ====
// Gathers qualified camera bytes into 32-bit words, first byte in the MSB
// Each completed word is pushed to the buffer with a one-cycle write pulse
`default_nettype none

module cam_byte_packer #(
	parameter int BANK_DEPTH = cam_buf_pkg::BANK_DEPTH_DEF
) (
	input  logic                          WBs_CLK_i,
	input  logic                          WBs_RST_i,
	input  logic                          cam_byte_stb_i,  // One strobe per byte
	input  logic                          cam_href_i,      // Line valid level
	input  logic                          cam_vsync_i,     // Frame valid level
	input  logic [cam_buf_pkg::CAM_BYTE_W-1:0] cam_dat_i,
	input  logic                          capture_en_i,
	cam_wr_if.producer                    wr
);
	import cam_buf_pkg::*;

	localparam int PTR_W = $clog2(2 * BANK_DEPTH);
	localparam int CNT_W = $clog2(BYTES_PER_WORD);
	localparam int SH_W  = (BYTES_PER_WORD - 1) * CAM_BYTE_W;  // Bytes held before the last

	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BYTES_PER_WORD - 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(2 * BANK_DEPTH - 1);

	logic [CNT_W-1:0] byte_cnt;   // Bytes already in the partial word
	logic [SH_W-1:0]  shift_q;    // Partial word, oldest byte on top
	logic [PTR_W-1:0] wr_ptr;     // Next word index
	logic             byte_ok;
	logic             word_done;

	// Byte counts only while line, frame and capture are all valid
	assign byte_ok   = cam_byte_stb_i & cam_href_i & cam_vsync_i & capture_en_i;
	assign word_done = byte_ok & (byte_cnt == LAST_CNT);

	// ----------------------------------------
	// Byte counter, shifter and write pointer
	// ----------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			byte_cnt <= '0;
			shift_q  <= '0;
			wr_ptr   <= '0;
			wr.wr_en <= 1'b0;
		end else begin
			wr.wr_en <= word_done;  // Pulse on the fourth byte
			if (word_done) begin
				byte_cnt <= '0;
				shift_q  <= '0;
				if (wr_ptr == LAST_PTR)
					wr_ptr <= '0;  // Both banks full
				else
					wr_ptr <= wr_ptr + 1'b1;
			end else if (byte_ok) begin
				byte_cnt <= byte_cnt + 1'b1;
				shift_q  <= {shift_q[SH_W-CAM_BYTE_W-1:0], cam_dat_i};
			end
			// Unqualified bytes leave the partial word alone
		end
	end

	// Word and its address are taken before the pointer moves
	always_ff @(posedge WBs_CLK_i) begin
		if (word_done) begin
			wr.wr_data <= {shift_q, cam_dat_i};
			wr.wr_addr <= wr_ptr;
		end
	end

	assign wr.wr_bank = wr_ptr[PTR_W-1];  // Top bit picks the bank

	// Words are at least four cycles apart
	a_wr_en_single: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wr.wr_en |=> !wr.wr_en);

endmodule

`default_nettype wire

// ==== hdl/wb_reg_slave.sv ====
// Host-side slave for the capture block
// Decodes the buffer and control cycles, returns buffer data or status
`default_nettype none

module wb_reg_slave #(
	parameter int BANK_DEPTH = cam_buf_pkg::BANK_DEPTH_DEF
) (
	input  logic                             WBs_CLK_i,
	input  logic                             WBs_RST_i,
	input  logic [cam_buf_pkg::ADR_W-1:0]    wbs_adr_i,
	input  logic                             wbs_buf_cyc_i,   // Buffer read cycle
	input  logic                             wbs_ctrl_cyc_i,  // Control and status cycle
	input  logic                             wbs_stb_i,
	input  logic                             wbs_we_i,
	input  logic [cam_buf_pkg::DATA_W-1:0]   wbs_dat_i,
	output logic [cam_buf_pkg::DATA_W-1:0]   wbs_dat_o,
	output logic                             wbs_ack_o,
	input  logic                             cam_vsync_i,
	cam_wr_if.monitor                        mon,
	output logic                             capture_en_o,
	output logic [$clog2(2*BANK_DEPTH)-1:0]  rd_addr_o,
	input  logic [cam_buf_pkg::DATA_W-1:0]   rd_data_i
);
	import cam_buf_pkg::*;

	localparam int PTR_W = $clog2(2 * BANK_DEPTH);

	ctrl_word_u        ctrl_q;      // Control register
	logic [DATA_W-1:0] status_nxt;
	logic [DATA_W-1:0] status_q;
	logic              ack_nxt;
	logic              ctrl_wr;

	// ----------------------------------------
	// Acknowledge and register write decode
	// ----------------------------------------
	assign ack_nxt = (wbs_buf_cyc_i | wbs_ctrl_cyc_i) & wbs_stb_i & ~wbs_ack_o;
	assign ctrl_wr = wbs_ctrl_cyc_i & wbs_stb_i & wbs_we_i & ~wbs_ack_o;

	always_comb begin
		status_nxt                 = '0;
		status_nxt[STAT_BANK_BIT]  = mon.wr_bank;
		status_nxt[STAT_VSYNC_BIT] = cam_vsync_i;
		status_nxt[STAT_CAPEN_BIT] = ctrl_q.f.capture_en;
	end

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wbs_ack_o  <= 1'b0;
			ctrl_q.raw <= '0;  // Capture off
			status_q   <= '0;
		end else begin
			wbs_ack_o <= ack_nxt;
			status_q  <= status_nxt;
			if (ctrl_wr)
				ctrl_q.raw <= wbs_dat_i;  // Lands with the ack edge
		end
	end

	assign capture_en_o = ctrl_q.f.capture_en;

	// Buffer read is one cycle, so data is ready with the ack
	assign rd_addr_o = wbs_adr_i[PTR_W-1:0];
	assign wbs_dat_o = wbs_ctrl_cyc_i ? status_q : rd_data_i;

	// ----------------------------------------
	// Host protocol checks
	// ----------------------------------------
	a_ack_pulse: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wbs_ack_o |=> !wbs_ack_o);

	a_cyc_onehot: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		!(wbs_buf_cyc_i && wbs_ctrl_cyc_i));

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
// Two-bank ping-pong word store for captured frames
// Camera words are written in, the host reads back one word per cycle
`default_nettype none

module frame_buffer #(
	parameter int BANK_DEPTH = cam_buf_pkg::BANK_DEPTH_DEF
) (
	input  logic                            WBs_CLK_i,
	cam_wr_if.buffer                        wr,
	input  logic [$clog2(2*BANK_DEPTH)-1:0] rd_addr_i,
	output logic [cam_buf_pkg::DATA_W-1:0]  rd_data_o
);
	import cam_buf_pkg::*;

	localparam int DEPTH = 2 * BANK_DEPTH;  // Bank 0 then bank 1
	localparam int PTR_W = $clog2(DEPTH);

	logic [DATA_W-1:0] mem [DEPTH];

	// ----------------------------------------
	// Write port
	// ----------------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		if (wr.wr_en)
			mem[wr.wr_addr] <= wr.wr_data;
	end

	// ----------------------------------------
	// Read port
	// ----------------------------------------
	// Registered read with data one cycle after the address
	always_ff @(posedge WBs_CLK_i) begin
		rd_data_o <= mem[rd_addr_i];
	end

	// Packer pointer must stay inside the two banks
	a_wr_in_range: assert property (@(posedge WBs_CLK_i)
		wr.wr_en |-> ({1'b0, wr.wr_addr} < (PTR_W + 1)'(DEPTH)));

endmodule

`default_nettype wire

// ==== hdl/cam_capture_top.sv ====
// Top level of the camera frame-capture block
// Byte packer and host slave side by side around a shared frame buffer
`default_nettype none

module cam_capture_top #(
	parameter int BANK_DEPTH = cam_buf_pkg::BANK_DEPTH_DEF
) (
	input  logic                               WBs_CLK_i,
	input  logic                               WBs_RST_i,
	// Host bus
	input  logic [cam_buf_pkg::ADR_W-1:0]      wbs_adr_i,
	input  logic                               wbs_buf_cyc_i,
	input  logic                               wbs_ctrl_cyc_i,
	input  logic                               wbs_stb_i,
	input  logic                               wbs_we_i,
	input  logic [cam_buf_pkg::DATA_W-1:0]     wbs_dat_i,
	output logic [cam_buf_pkg::DATA_W-1:0]     wbs_dat_o,
	output logic                               wbs_ack_o,
	// Camera
	input  logic                               cam_byte_stb_i,
	input  logic                               cam_href_i,
	input  logic                               cam_vsync_i,
	input  logic [cam_buf_pkg::CAM_BYTE_W-1:0] cam_dat_i
);
	import cam_buf_pkg::*;

	localparam int PTR_W = $clog2(2 * BANK_DEPTH);

	logic              capture_en;
	logic [PTR_W-1:0]  rd_addr;
	logic [DATA_W-1:0] rd_data;

	cam_wr_if #(.BANK_DEPTH(BANK_DEPTH)) wr_bus ();  // Packer write stream

	// ----------------------------------------
	// Camera side
	// ----------------------------------------
	cam_byte_packer #(.BANK_DEPTH(BANK_DEPTH)) u_packer (
		.WBs_CLK_i      (WBs_CLK_i),
		.WBs_RST_i      (WBs_RST_i),
		.cam_byte_stb_i (cam_byte_stb_i),
		.cam_href_i     (cam_href_i),
		.cam_vsync_i    (cam_vsync_i),
		.cam_dat_i      (cam_dat_i),
		.capture_en_i   (capture_en),
		.wr             (wr_bus.producer)
	);

	// ----------------------------------------
	// Host side
	// ----------------------------------------
	wb_reg_slave #(.BANK_DEPTH(BANK_DEPTH)) u_slave (
		.WBs_CLK_i      (WBs_CLK_i),
		.WBs_RST_i      (WBs_RST_i),
		.wbs_adr_i      (wbs_adr_i),
		.wbs_buf_cyc_i  (wbs_buf_cyc_i),
		.wbs_ctrl_cyc_i (wbs_ctrl_cyc_i),
		.wbs_stb_i      (wbs_stb_i),
		.wbs_we_i       (wbs_we_i),
		.wbs_dat_i      (wbs_dat_i),
		.wbs_dat_o      (wbs_dat_o),
		.wbs_ack_o      (wbs_ack_o),
		.cam_vsync_i    (cam_vsync_i),
		.mon            (wr_bus.monitor),
		.capture_en_o   (capture_en),
		.rd_addr_o      (rd_addr),
		.rd_data_i      (rd_data)
	);

	frame_buffer #(.BANK_DEPTH(BANK_DEPTH)) u_fbuf (
		.WBs_CLK_i (WBs_CLK_i),
		.wr        (wr_bus.buffer),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

endmodule

`default_nettype wire

// ==== include/tb_model.svh ====
// Reference model functions for the capture testbench
// Included inside the testbench module, gives expected words and status
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Four bytes in arrival order, first byte lands in the MSB
function automatic logic [cam_buf_pkg::DATA_W-1:0] model_pack_word(
	input logic [cam_buf_pkg::CAM_BYTE_W-1:0] b0,
	input logic [cam_buf_pkg::CAM_BYTE_W-1:0] b1,
	input logic [cam_buf_pkg::CAM_BYTE_W-1:0] b2,
	input logic [cam_buf_pkg::CAM_BYTE_W-1:0] b3
);
	return {b0, b1, b2, b3};
endfunction

// Expected status from the number of words written so far
function automatic logic [cam_buf_pkg::DATA_W-1:0] model_status(
	input int unsigned wr_count,
	input int unsigned bank_depth,
	input logic        vsync,
	input logic        capture_en
);
	logic [cam_buf_pkg::DATA_W-1:0] st;
	int unsigned                    slot;

	slot = wr_count % (2 * bank_depth);  // Pointer wraps over both banks
	st   = '0;
	st[cam_buf_pkg::STAT_BANK_BIT]  = (slot >= bank_depth);
	st[cam_buf_pkg::STAT_VSYNC_BIT] = vsync;
	st[cam_buf_pkg::STAT_CAPEN_BIT] = capture_en;
	return st;
endfunction

`endif

// ==== tests/tb_cam_capture.sv ====
// Testbench for the camera capture block
// Drives camera bytes and host cycles and checks buffer words and status against the model
`default_nettype none

module tb_cam_capture;
	import cam_buf_pkg::*;

	localparam int BANK_DEPTH  = BANK_DEPTH_DEF;
	localparam int DEPTH       = 2 * BANK_DEPTH;
	localparam int TOTAL_BYTES = 4 * (DEPTH + 1) + 256;   // Wrap test dominates
	localparam longint WD_LIMIT = longint'(TOTAL_BYTES) * 4 * 10 + 50000;

	`include "tb_model.svh"

	logic                  WBs_CLK_i, WBs_RST_i;
	logic [ADR_W-1:0]      wbs_adr_i;
	logic                  wbs_buf_cyc_i, wbs_ctrl_cyc_i, wbs_stb_i, wbs_we_i;
	logic [DATA_W-1:0]     wbs_dat_i, wbs_dat_o;
	logic                  wbs_ack_o;
	logic                  cam_byte_stb_i, cam_href_i, cam_vsync_i;
	logic [CAM_BYTE_W-1:0] cam_dat_i;

	logic [DATA_W-1:0]     exp_mem [DEPTH];   // Expected buffer contents
	logic [CAM_BYTE_W-1:0] pend_q[$];         // Qualified bytes of the open word
	int unsigned           wr_count;          // Words written so far
	logic                  cap_en_model, vsync_lvl, ack_last;
	string                 sig_q[$];
	logic [DATA_W-1:0]     exp_q[$], act_q[$];
	int                    checks, errors;

	cam_capture_top #(.BANK_DEPTH(BANK_DEPTH)) uut (.*);

	always #5 WBs_CLK_i = ~WBs_CLK_i;

	// ----------------------------------------
	// Compare and protocol monitors
	// ----------------------------------------
	always @(negedge WBs_CLK_i) begin
		while (act_q.size() > 0) begin
			checks = checks + 1;
			if (act_q[0] !== exp_q[0]) begin
				errors = errors + 1;
				$display("ERROR time=%0t %s expected=%08h actual=%08h",
					$time, sig_q[0], exp_q[0], act_q[0]);
			end
			void'(sig_q.pop_front());
			void'(exp_q.pop_front());
			void'(act_q.pop_front());
		end
	end

	always @(negedge WBs_CLK_i) begin
		if (wbs_ack_o && ack_last) begin
			errors = errors + 1;
			$display("Acknowledge held high for two cycles at time %0t", $time);
		end
		ack_last = wbs_ack_o;
	end

	// Watchdog sized from the byte count
	initial begin
		#(WD_LIMIT);
		$display("Run did not finish within %0d time units", WD_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	// ----------------------------------------
	// Host and camera tasks
	// ----------------------------------------
	task automatic push_check(input string name, input logic [DATA_W-1:0] e,
		input logic [DATA_W-1:0] a);
		sig_q.push_back(name);
		exp_q.push_back(e);
		act_q.push_back(a);
	endtask

	task automatic host_cycle(input logic is_ctrl, input logic we, input logic [ADR_W-1:0] adr,
		input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
		int waited;
		waited = 0;
		@(posedge WBs_CLK_i);
		wbs_ctrl_cyc_i <= is_ctrl;
		wbs_buf_cyc_i  <= ~is_ctrl;
		wbs_stb_i      <= 1'b1;
		wbs_we_i       <= we;
		wbs_adr_i      <= adr;
		wbs_dat_i      <= wdat;
		do begin
			@(negedge WBs_CLK_i);  // Sample away from the drive edge
			waited = waited + 1;
		end while (!wbs_ack_o && waited < 16);
		if (!wbs_ack_o) begin
			errors = errors + 1;
			$display("No acknowledge within 16 cycles at time %0t", $time);
		end
		rdat = wbs_dat_o;
		@(posedge WBs_CLK_i);
		wbs_ctrl_cyc_i <= 1'b0;
		wbs_buf_cyc_i  <= 1'b0;
		wbs_stb_i      <= 1'b0;
		wbs_we_i       <= 1'b0;
	endtask

	task automatic write_ctrl(input logic en);
		ctrl_word_u        w;
		logic [DATA_W-1:0] rd;
		w.raw          = '0;
		w.f.capture_en = en;
		host_cycle(1'b1, 1'b1, '0, w.raw, rd);
		cap_en_model = en;  // Took effect on the ack edge
	endtask

	task automatic check_status();
		logic [DATA_W-1:0] rd;
		host_cycle(1'b1, 1'b0, '0, '0, rd);
		push_check("wbs_dat_o status", model_status(wr_count, BANK_DEPTH, vsync_lvl,
			cap_en_model), rd);
	endtask

	task automatic check_word(input int idx);
		logic [DATA_W-1:0] rd;
		host_cycle(1'b0, 1'b0, ADR_W'(idx), '0, rd);
		push_check($sformatf("wbs_dat_o buf[%0d]", idx), exp_mem[idx], rd);
	endtask

	task automatic send_byte(input logic href, input logic vsync, input logic [7:0] dat);
		int gap;
		gap = $urandom_range(0, 2);
		repeat (gap) begin
			@(posedge WBs_CLK_i);
			cam_byte_stb_i <= 1'b0;
		end
		@(posedge WBs_CLK_i);
		cam_byte_stb_i <= 1'b1;
		cam_href_i     <= href;
		cam_vsync_i    <= vsync;
		cam_dat_i      <= dat;
		vsync_lvl      = vsync;
		if (href && vsync && cap_en_model) begin
			pend_q.push_back(dat);
			if (pend_q.size() == BYTES_PER_WORD) begin
				exp_mem[wr_count % DEPTH] = model_pack_word(pend_q[0], pend_q[1],
					pend_q[2], pend_q[3]);
				pend_q.delete();
				wr_count = wr_count + 1;
			end
		end
	endtask

	task automatic stb_off();
		@(posedge WBs_CLK_i);
		cam_byte_stb_i <= 1'b0;
	endtask

	task automatic send_words(input int n);
		for (int i = 0; i < 4 * n; i++)
			send_byte(1'b1, 1'b1, 8'($urandom));
		stb_off();
	endtask

	task automatic set_vsync(input logic v);
		@(posedge WBs_CLK_i);
		cam_vsync_i <= v;
		vsync_lvl   = v;
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		int start;
		void'($urandom(16));  // One seed for the whole run
		WBs_CLK_i      = 1'b0;
		WBs_RST_i      = 1'b1;
		wbs_adr_i      = '0;
		wbs_buf_cyc_i  = 1'b0;
		wbs_ctrl_cyc_i = 1'b0;
		wbs_stb_i      = 1'b0;
		wbs_we_i       = 1'b0;
		wbs_dat_i      = '0;
		cam_byte_stb_i = 1'b0;
		cam_href_i     = 1'b0;
		cam_vsync_i    = 1'b0;
		cam_dat_i      = '0;
		wr_count       = 0;
		cap_en_model   = 1'b0;
		vsync_lvl      = 1'b0;
		ack_last       = 1'b0;
		checks         = 0;
		errors         = 0;
		repeat (5) @(posedge WBs_CLK_i);
		WBs_RST_i <= 1'b0;

		check_status();  // Bank 0 and capture off
		write_ctrl(1'b1);
		check_status();
		send_words(8);  // Consecutive words with MSB first
		for (int i = 0; i < 8; i++)
			check_word(i);

		start = int'(wr_count);  // Random href and vsync gaps
		for (int i = 0; i < 48; i++)
			send_byte($urandom_range(0, 3) != 0, $urandom_range(0, 3) != 0, 8'($urandom));
		stb_off();
		for (int i = start; i < int'(wr_count); i++)
			check_word(i);

		write_ctrl(1'b0);  // Capture off so the buffer stays frozen
		check_status();
		for (int i = 0; i < 16; i++)
			send_byte(1'b1, 1'b1, 8'($urandom));
		stb_off();
		for (int i = 0; i < int'(wr_count); i++)
			check_word(i);
		check_status();
		write_ctrl(1'b1);
		start = int'(wr_count);
		send_words(3);
		for (int i = start; i < int'(wr_count); i++)
			check_word(i);

		set_vsync(1'b0);  // Status vsync follows the pin
		check_status();
		set_vsync(1'b1);
		check_status();

		send_words(BANK_DEPTH - int'(wr_count));  // Into bank 1
		check_status();
		send_words(DEPTH - int'(wr_count));  // Wrapped to bank 0
		check_status();
		send_words(1);
		check_word(0);  // Newest word at address 0
		check_status();

		repeat (4) @(posedge WBs_CLK_i);
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hdl/cam_buf_pkg.sv
hdl/cam_wr_if.sv
hdl/cam_byte_packer.sv
hdl/wb_reg_slave.sv
hdl/frame_buffer.sv
hdl/cam_capture_top.sv
tests/tb_cam_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the capture testbench with Verilator and runs it
# Exit status is zero only when the log reports a pass

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_cam_capture

verilator --binary --timing --assert -f project.f --top-module "$TOP" \
	-Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
	echo "Simulation passed, see $LOG"
	exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
